// ==== periph_sys.f ====
+incdir+logic
logic/bus_pkg.sv
logic/timer_pkg.sv
logic/periph_bus_if.sv
logic/bus_interconnect.sv
logic/timer.sv
logic/irq_ctrl.sv
logic/periph_sys.sv
sim/periph_sys_tb.sv

// ==== sim/periph_sys_tb.sv ====
`default_nettype none

`include "periph_defines.svh"

module periph_sys_tb;

	localparam int run_limit = 20000;

	localparam logic [3:0] t0_ctrl = {`PERIPH_DEV_TIMER0, `TIMER_REG_CTRL};
	localparam logic [3:0] t0_preset = {`PERIPH_DEV_TIMER0, `TIMER_REG_PRESET};
	localparam logic [3:0] t0_count = {`PERIPH_DEV_TIMER0, `TIMER_REG_COUNT};
	localparam logic [3:0] t1_ctrl = {`PERIPH_DEV_TIMER1, `TIMER_REG_CTRL};
	localparam logic [3:0] t1_preset = {`PERIPH_DEV_TIMER1, `TIMER_REG_PRESET};
	localparam logic [3:0] t1_count = {`PERIPH_DEV_TIMER1, `TIMER_REG_COUNT};
	localparam logic [3:0] irq_pend = {`PERIPH_DEV_IRQ, `IRQ_REG_PENDING};
	localparam logic [3:0] irq_mask = {`PERIPH_DEV_IRQ, `IRQ_REG_MASK};
	localparam logic [3:0] irq_raw = {`PERIPH_DEV_IRQ, `IRQ_REG_RAW};

	// Control words, bit 3 allow_irq, bits 2:1 mode, bit 0 enable.
	localparam logic [31:0] ctrl_oneshot_run = 32'h9;
	localparam logic [31:0] ctrl_periodic_run = 32'hb;

	logic clk;
	logic rst;
	logic h0_req;
	logic h0_we;
	logic [`PERIPH_ADDR_W-1:0] h0_addr;
	logic [`PERIPH_DATA_W-1:0] h0_wdata;
	logic h0_gnt;
	logic [`PERIPH_DATA_W-1:0] h0_rdata;
	logic h1_req;
	logic h1_we;
	logic [`PERIPH_ADDR_W-1:0] h1_addr;
	logic [`PERIPH_DATA_W-1:0] h1_wdata;
	logic h1_gnt;
	logic [`PERIPH_DATA_W-1:0] h1_rdata;
	logic irq;

	// Register file model.
	logic [3:0] m_ctrl [2];
	logic [31:0] m_preset [2];
	logic [31:0] m_count [2];
	logic [1:0] m_mask;
	logic [1:0] m_pending;
	logic [1:0] m_raw;
	logic last_host;

	logic [31:0] seed = 32'h756821a3;
	logic [31:0] exp_rd [2];
	logic chk_rd [2];
	int pass_count = 0;
	int fail_count = 0;
	int fail_base = 0;
	int test_num = 0;
	int cycles = 0;

	periph_sys dut (
		.clk(clk),
		.rst(rst),
		.h0_req(h0_req),
		.h0_we(h0_we),
		.h0_addr(h0_addr),
		.h0_wdata(h0_wdata),
		.h0_gnt(h0_gnt),
		.h0_rdata(h0_rdata),
		.h1_req(h1_req),
		.h1_we(h1_we),
		.h1_addr(h1_addr),
		.h1_wdata(h1_wdata),
		.h1_gnt(h1_gnt),
		.h1_rdata(h1_rdata),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= run_limit) begin
			$display("timeout: the run did not finish within %0d cycles", run_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected read value from the register file model.
	function automatic logic [31:0] expect_read(input logic [3:0] addr);
		logic [1:0] dev;
		logic [1:0] rsel;
		logic [31:0] val;
		dev = addr[3:2];
		rsel = addr[1:0];
		val = '0;
		if (dev == 2'd0 || dev == 2'd1) begin
			case (rsel)
				2'd0: val = {28'd0, m_ctrl[dev[0]]};
				2'd1: val = m_preset[dev[0]];
				2'd2: val = m_count[dev[0]];
				default: val = '0;
			endcase
		end else if (dev == 2'd2) begin
			case (rsel)
				2'd0: val = {30'd0, m_pending};
				2'd1: val = {30'd0, m_mask};
				2'd2: val = {30'd0, m_raw};
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	function automatic void model_write(input logic [3:0] addr, input logic [31:0] data);
		logic [1:0] dev;
		logic [1:0] rsel;
		dev = addr[3:2];
		rsel = addr[1:0];
		if (dev == 2'd0 || dev == 2'd1) begin
			case (rsel)
				2'd0: m_ctrl[dev[0]] = data[3:0];
				2'd1: m_preset[dev[0]] = data;
				2'd2: m_count[dev[0]] = data;
				default: ;
			endcase
		end else if (dev == 2'd2) begin
			// Pending is write-one-to-clear, raw ignores writes.
			if (rsel == 2'd0) begin
				m_pending = m_pending & ~data[1:0];
			end else if (rsel == 2'd1) begin
				m_mask = data[1:0];
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) begin
			pass_count++;
		end else begin
			$display("error: %s expected %h got %h", name, exp, got);
			fail_count++;
		end
	endtask

	// One bus transfer. Holds the request until the grant cycle.
	task automatic bus_access(input logic host, input logic we, input logic [3:0] addr,
			input logic [31:0] wdata, input logic check, output logic [31:0] rdata);
		@(posedge clk);
		if (host) begin
			h1_req <= 1'b1;
			h1_we <= we;
			h1_addr <= addr;
			h1_wdata <= wdata;
		end else begin
			h0_req <= 1'b1;
			h0_we <= we;
			h0_addr <= addr;
			h0_wdata <= wdata;
		end
		exp_rd[host] = expect_read(addr);
		chk_rd[host] = check && !we;
		@(negedge clk);
		while (host ? !h1_gnt : !h0_gnt) begin
			@(negedge clk);
		end
		rdata = host ? h1_rdata : h0_rdata;
		last_host = host;
		if (we) begin
			model_write(addr, wdata);
		end
		@(posedge clk);
		chk_rd[host] = 1'b0;
		if (host) begin
			h1_req <= 1'b0;
		end else begin
			h0_req <= 1'b0;
		end
	endtask

	task automatic write_reg(input logic host, input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(host, 1'b1, addr, data, 1'b0, unused);
	endtask

	task automatic check_reg(input logic host, input logic [3:0] addr);
		logic [31:0] unused;
		bus_access(host, 1'b0, addr, '0, 1'b1, unused);
	endtask

	task automatic peek_reg(input logic host, input logic [3:0] addr, output logic [31:0] data);
		bus_access(host, 1'b0, addr, '0, 1'b0, data);
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (irq !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		assert (irq === level) begin
			pass_count++;
		end else begin
			$display("irq did not go %s within %0d cycles", level ? "high" : "low", limit);
			fail_count++;
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("test %0d %s: %s (%0d errors)", test_num, name,
			(fail_count == fail_base) ? "ok" : "failed", fail_count - fail_base);
		fail_base = fail_count;
	endtask

	// Compare each granted read against the model.
	always @(negedge clk) begin
		if (chk_rd[0] && h0_gnt) begin
			assert (h0_rdata === exp_rd[0]) begin
				pass_count++;
			end else begin
				$display("error: h0_rdata expected %h got %h", exp_rd[0], h0_rdata);
				fail_count++;
			end
		end
		if (chk_rd[1] && h1_gnt) begin
			assert (h1_rdata === exp_rd[1]) begin
				pass_count++;
			end else begin
				$display("error: h1_rdata expected %h got %h", exp_rd[1], h1_rdata);
				fail_count++;
			end
		end
	end

	initial begin
		logic [31:0] data;
		logic [31:0] p;
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] rd;
		logic [3:0] addr;
		logic host;
		logic win;
		int start;

		rst <= 1'b1;
		h0_req <= 1'b0;
		h0_we <= 1'b0;
		h0_addr <= '0;
		h0_wdata <= '0;
		h1_req <= 1'b0;
		h1_we <= 1'b0;
		h1_addr <= '0;
		h1_wdata <= '0;
		for (int i = 0; i < 2; i++) begin
			m_ctrl[i] = '0;
			m_preset[i] = '0;
			m_count[i] = '0;
			chk_rd[i] = 1'b0;
			exp_rd[i] = '0;
		end
		m_mask = '0;
		m_pending = '0;
		m_raw = '0;
		last_host = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		check_value("irq", irq, 32'd0);
		for (int h = 0; h < 2; h++) begin
			for (int a = 0; a < 16; a++) begin
				check_reg(h[0], a[3:0]);
			end
		end
		seed = lcg_next(seed);
		write_reg(1'b0, 4'hd, seed);
		check_reg(1'b1, 4'hd);
		finish_test("reset values");

		for (int i = 0; i < 24; i++) begin
			seed = lcg_next(seed);
			host = seed[31];
			addr = seed[19:16];
			seed = lcg_next(seed);
			data = seed;
			// Timers stay stopped here.
			if (addr[3] == 1'b0 && addr[1:0] == 2'd0) begin
				data[0] = 1'b0;
			end
			write_reg(host, addr, data);
			check_reg(~host, addr);
		end
		finish_test("random register access");

		// Host 1 served last, so host 0 takes the first conflict.
		check_reg(1'b1, t0_preset);
		@(posedge clk);
		seed = lcg_next(seed);
		h0_req <= 1'b1;
		h0_we <= 1'b1;
		h0_addr <= t0_preset;
		h0_wdata <= seed;
		seed = lcg_next(seed);
		h1_req <= 1'b1;
		h1_we <= 1'b1;
		h1_addr <= t0_preset;
		h1_wdata <= seed;
		for (int i = 0; i < 8; i++) begin
			win = ~last_host;
			@(negedge clk);
			check_value("h0_gnt", h0_gnt, !win);
			check_value("h1_gnt", h1_gnt, win);
			model_write(t0_preset, win ? h1_wdata : h0_wdata);
			last_host = win;
			@(posedge clk);
			seed = lcg_next(seed);
			if (win) begin
				h1_wdata <= seed;
			end else begin
				h0_wdata <= seed;
			end
		end
		h0_req <= 1'b0;
		h1_req <= 1'b0;
		check_reg(1'b0, t0_preset);
		finish_test("arbitration");

		seed = lcg_next(seed);
		p = (seed >> 8) % 40 + 1;
		write_reg(1'b0, t0_preset, p);
		write_reg(1'b0, irq_mask, 32'h3);
		write_reg(1'b1, t0_ctrl, ctrl_oneshot_run);
		wait_irq(1'b1, p + 10);
		// One-shot expiry clears enable and holds the interrupt.
		m_ctrl[0] = 4'h8;
		m_count[0] = '0;
		m_pending[0] = 1'b1;
		m_raw[0] = 1'b1;
		check_reg(1'b0, irq_pend);
		check_reg(1'b1, t0_count);
		check_reg(1'b0, t0_ctrl);
		check_reg(1'b1, irq_raw);
		@(negedge clk);
		check_value("irq", irq, 32'd1);
		write_reg(1'b0, t0_ctrl, 32'h0);
		m_raw[0] = 1'b0;
		write_reg(1'b0, irq_pend, 32'h1);
		check_reg(1'b1, irq_pend);
		wait_irq(1'b0, 4);
		finish_test("one-shot timer");

		seed = lcg_next(seed);
		p = (seed >> 8) % 32 + 12;
		write_reg(1'b1, t1_preset, p);
		write_reg(1'b1, t1_ctrl, ctrl_periodic_run);
		wait_irq(1'b1, p + 10);
		m_pending[1] = 1'b1;
		write_reg(1'b0, irq_pend, 32'h2);
		wait_irq(1'b0, 2);
		wait_irq(1'b1, p + 10);
		m_pending[1] = 1'b1;
		// Reload takes a few cycles after the pulse.
		c1 = '0;
		for (int i = 0; i < 10 && c1 == 0; i++) begin
			peek_reg(1'b1, t1_count, c1);
		end
		peek_reg(1'b1, t1_count, c2);
		assert (c1 > 0 && c1 <= p && c2 < c1) begin
			pass_count++;
		end else begin
			$display("error: count read %h then %h with preset %h", c1, c2, p);
			fail_count++;
		end
		finish_test("periodic timer");

		write_reg(1'b1, t1_ctrl, 32'h0);
		write_reg(1'b0, irq_pend, 32'h3);
		write_reg(1'b0, irq_mask, 32'h0);
		@(negedge clk);
		check_value("irq", irq, 32'd0);
		seed = lcg_next(seed);
		p = (seed >> 8) % 40 + 1;
		write_reg(1'b0, t0_preset, p);
		write_reg(1'b0, t0_ctrl, ctrl_oneshot_run);
		start = cycles;
		rd = '0;
		while (!rd[0] && cycles - start < p + 20) begin
			peek_reg(1'b1, irq_raw, rd);
			@(negedge clk);
			check_value("irq", irq, 32'd0);
		end
		assert (rd[0]) begin
			pass_count++;
		end else begin
			$display("timer 0 interrupt never showed on the raw word");
			fail_count++;
		end
		m_ctrl[0] = 4'h8;
		m_count[0] = '0;
		m_pending = 2'b01;
		m_raw = 2'b01;
		check_reg(1'b0, irq_pend);
		check_reg(1'b1, irq_raw);
		check_reg(1'b0, t0_ctrl);
		@(negedge clk);
		check_value("irq", irq, 32'd0);
		write_reg(1'b1, irq_mask, 32'h1);
		@(negedge clk);
		check_value("irq", irq, 32'd1);
		finish_test("interrupt mask");

		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/periph_sys.sv ====
`default_nettype none

`include "periph_defines.svh"

module periph_sys (
	input logic clk,
	input logic rst,

	input logic h0_req,
	input logic h0_we,
	input logic [`PERIPH_ADDR_W-1:0] h0_addr,
	input logic [`PERIPH_DATA_W-1:0] h0_wdata,
	output logic h0_gnt,
	output logic [`PERIPH_DATA_W-1:0] h0_rdata,

	input logic h1_req,
	input logic h1_we,
	input logic [`PERIPH_ADDR_W-1:0] h1_addr,
	input logic [`PERIPH_DATA_W-1:0] h1_wdata,
	output logic h1_gnt,
	output logic [`PERIPH_DATA_W-1:0] h1_rdata,

	output logic irq
);

	logic [`PERIPH_DATA_W-1:0] timer0_rdata;
	logic [`PERIPH_DATA_W-1:0] timer1_rdata;
	logic [`PERIPH_DATA_W-1:0] irq_rdata;
	// Bit n carries the interrupt of timer n.
	logic [`IRQ_SOURCES-1:0] timer_irq;

	periph_bus_if u_bus ();

	bus_interconnect u_interconnect (
		.clk(clk),
		.rst(rst),
		.h0_req(h0_req),
		.h0_we(h0_we),
		.h0_addr(h0_addr),
		.h0_wdata(h0_wdata),
		.h0_gnt(h0_gnt),
		.h0_rdata(h0_rdata),
		.h1_req(h1_req),
		.h1_we(h1_we),
		.h1_addr(h1_addr),
		.h1_wdata(h1_wdata),
		.h1_gnt(h1_gnt),
		.h1_rdata(h1_rdata),
		.bus(u_bus.ctrl),
		.timer0_rdata(timer0_rdata),
		.timer1_rdata(timer1_rdata),
		.irq_rdata(irq_rdata)
	);

	timer u_timer0 (
		.clk(clk),
		.rst(rst),
		.bus(u_bus.dev),
		.dev_sel(u_bus.sel[`PERIPH_DEV_TIMER0]),
		.rdata(timer0_rdata),
		.irq(timer_irq[0])
	);

	timer u_timer1 (
		.clk(clk),
		.rst(rst),
		.bus(u_bus.dev),
		.dev_sel(u_bus.sel[`PERIPH_DEV_TIMER1]),
		.rdata(timer1_rdata),
		.irq(timer_irq[1])
	);

	irq_ctrl u_irq_ctrl (
		.clk(clk),
		.rst(rst),
		.bus(u_bus.dev),
		.dev_sel(u_bus.sel[`PERIPH_DEV_IRQ]),
		.src(timer_irq),
		.rdata(irq_rdata),
		.irq(irq)
	);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
`default_nettype none

`include "periph_defines.svh"

module irq_ctrl (
	input logic clk,
	input logic rst,
	periph_bus_if.dev bus,
	input logic dev_sel,
	input logic [`IRQ_SOURCES-1:0] src,
	output logic [`PERIPH_DATA_W-1:0] rdata,
	output logic irq
);

	logic [`IRQ_SOURCES-1:0] pending;
	logic [`IRQ_SOURCES-1:0] mask;
	logic [`IRQ_SOURCES-1:0] clr;
	logic wr_en;

	assign wr_en = dev_sel && bus.we;

	// Write-one-to-clear on the pending word.
	always_comb begin
		clr = '0;
		if (wr_en && bus.addr.field.regsel == `IRQ_REG_PENDING) begin
			clr = bus.wdata[`IRQ_SOURCES-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			mask <= '0;
		end else begin
			// A source that is high wins over a clear.
			pending <= (pending & ~clr) | src;
			if (wr_en && bus.addr.field.regsel == `IRQ_REG_MASK) begin
				mask <= bus.wdata[`IRQ_SOURCES-1:0];
			end
		end
	end

	assign irq = |(pending & mask);

	// Raw word shows the live source levels.
	always_comb begin
		rdata = '0;
		case (bus.addr.field.regsel)
			`IRQ_REG_PENDING: rdata[`IRQ_SOURCES-1:0] = pending;
			`IRQ_REG_MASK: rdata[`IRQ_SOURCES-1:0] = mask;
			`IRQ_REG_RAW: rdata[`IRQ_SOURCES-1:0] = src;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/timer.sv ====
`default_nettype none

`include "periph_defines.svh"

module timer import timer_pkg::*; (
	input logic clk,
	input logic rst,
	periph_bus_if.dev bus,
	input logic dev_sel,
	output logic [`PERIPH_DATA_W-1:0] rdata,
	output logic irq
);

	timer_ctrl_s ctrl;
	timer_state_e state;
	logic [`PERIPH_DATA_W-1:0] preset;
	logic [`PERIPH_DATA_W-1:0] count;
	logic irq_latch;
	logic wr_en;

	assign wr_en = dev_sel && bus.we;

	// Interrupt is only visible when allowed.
	assign irq = irq_latch && ctrl.allow_irq;

	// Register read. Word 3 reads as zero.
	always_comb begin
		rdata = '0;
		case (bus.addr.field.regsel)
			`TIMER_REG_CTRL: rdata[$bits(timer_ctrl_s)-1:0] = ctrl;
			`TIMER_REG_PRESET: rdata = preset;
			`TIMER_REG_COUNT: rdata = count;
			default: rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= '0;
			preset <= '0;
			count <= '0;
			state <= state_idle;
			irq_latch <= 1'b0;
		end else if (wr_en) begin
			// A bus write holds the FSM for this cycle.
			case (bus.addr.field.regsel)
				`TIMER_REG_CTRL: begin
					ctrl <= timer_ctrl_s'(bus.wdata[$bits(timer_ctrl_s)-1:0]);
				end
				`TIMER_REG_PRESET: preset <= bus.wdata;
				`TIMER_REG_COUNT: count <= bus.wdata;
				default: ;
			endcase
		end else begin
			case (state)
				state_idle: begin
					if (ctrl.enable) begin
						irq_latch <= 1'b0;
						state <= state_load;
					end
				end

				state_load: begin
					count <= preset;
					state <= state_count;
				end

				state_count: begin
					if (!ctrl.enable) begin
						state <= state_idle;
					end else if (count > 1) begin
						count <= count - 1'b1;
					end else begin
						// Expired.
						count <= '0;
						irq_latch <= 1'b1;
						state <= state_irq;
					end
				end

				state_irq: begin
					state <= state_idle;
					// One-shot stops itself, other modes drop irq and reload
					if (ctrl.mode == mode_oneshot) begin
						ctrl.enable <= 1'b0;
					end else begin
						irq_latch <= 1'b0;
					end
				end

				default: state <= state_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/bus_interconnect.sv ====
`default_nettype none

`include "periph_defines.svh"

module bus_interconnect import bus_pkg::*; (
	input logic clk,
	input logic rst,

	input logic h0_req,
	input logic h0_we,
	input logic [`PERIPH_ADDR_W-1:0] h0_addr,
	input logic [`PERIPH_DATA_W-1:0] h0_wdata,
	output logic h0_gnt,
	output logic [`PERIPH_DATA_W-1:0] h0_rdata,

	input logic h1_req,
	input logic h1_we,
	input logic [`PERIPH_ADDR_W-1:0] h1_addr,
	input logic [`PERIPH_DATA_W-1:0] h1_wdata,
	output logic h1_gnt,
	output logic [`PERIPH_DATA_W-1:0] h1_rdata,

	periph_bus_if.ctrl bus,

	input logic [`PERIPH_DATA_W-1:0] timer0_rdata,
	input logic [`PERIPH_DATA_W-1:0] timer1_rdata,
	input logic [`PERIPH_DATA_W-1:0] irq_rdata
);

	host_idx_t last_gnt;
	host_idx_t gnt_idx;
	logic gnt0;
	logic gnt1;
	logic any_gnt;
	logic cmd_we;
	bus_addr_u cmd_addr;
	logic [`PERIPH_DATA_W-1:0] cmd_wdata;
	logic [`PERIPH_DATA_W-1:0] rd_mux;

	// Round robin. On a conflict the host not served last wins.
	always_comb begin
		gnt0 = h0_req && (!h1_req || last_gnt == host_idx_t'(1'b1));
		gnt1 = h1_req && (!h0_req || last_gnt == host_idx_t'(1'b0));
		any_gnt = gnt0 || gnt1;
		gnt_idx = host_idx_t'(gnt1);
	end

	assign h0_gnt = gnt0;
	assign h1_gnt = gnt1;

	always_ff @(posedge clk) begin
		if (rst) begin
			// Host 0 takes the first conflict.
			last_gnt <= host_idx_t'(1'b1);
		end else if (any_gnt) begin
			last_gnt <= gnt_idx;
		end
	end

	// Put the granted host's command on the shared bus.
	always_comb begin
		if (gnt_idx == host_idx_t'(1'b1)) begin
			cmd_we = h1_we;
			cmd_addr.word = h1_addr;
			cmd_wdata = h1_wdata;
		end else begin
			cmd_we = h0_we;
			cmd_addr.word = h0_addr;
			cmd_wdata = h0_wdata;
		end
	end

	assign bus.we = any_gnt && cmd_we;
	assign bus.addr = cmd_addr;
	assign bus.wdata = cmd_wdata;

	// Device decode. The fourth device slot selects nothing.
	always_comb begin
		bus.sel = 3'b000;
		if (any_gnt) begin
			case (cmd_addr.field.dev)
				`PERIPH_DEV_TIMER0: bus.sel[0] = 1'b1;
				`PERIPH_DEV_TIMER1: bus.sel[1] = 1'b1;
				`PERIPH_DEV_IRQ: bus.sel[2] = 1'b1;
				default: bus.sel = 3'b000;
			endcase
		end
	end

	// Read data back from the addressed device, zero if unmapped.
	always_comb begin
		case (cmd_addr.field.dev)
			`PERIPH_DEV_TIMER0: rd_mux = timer0_rdata;
			`PERIPH_DEV_TIMER1: rd_mux = timer1_rdata;
			`PERIPH_DEV_IRQ: rd_mux = irq_rdata;
			default: rd_mux = '0;
		endcase
	end

	assign h0_rdata = gnt0 ? rd_mux : '0;
	assign h1_rdata = gnt1 ? rd_mux : '0;

endmodule

`default_nettype wire

// ==== logic/periph_bus_if.sv ====
`default_nettype none

`include "periph_defines.svh"

interface periph_bus_if import bus_pkg::*; ();

	// One select level per device.
	logic [2:0] sel;
	logic we;
	bus_addr_u addr;
	logic [`PERIPH_DATA_W-1:0] wdata;

	modport ctrl (
		output sel,
		output we,
		output addr,
		output wdata
	);

	// Devices get their own select as a separate port.
	modport dev (
		input we,
		input addr,
		input wdata
	);

endinterface

`default_nettype wire

// ==== logic/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

	typedef enum logic [1:0] {
		state_idle,
		state_load,
		state_count,
		state_irq
	} timer_state_e;

	// Codes 2 and 3 are not named and behave as periodic.
	typedef enum logic [1:0] {
		mode_oneshot = 2'd0,
		mode_periodic = 2'd1
	} timer_mode_e;

	// Control word layout, from bit 3 down to bit 0.
	typedef struct packed {
		logic allow_irq;
		timer_mode_e mode;
		logic enable;
	} timer_ctrl_s;

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
`default_nettype none

`include "periph_defines.svh"

package bus_pkg;

	// Upper half picks the device, lower half the register word.
	typedef struct packed {
		logic [1:0] dev;
		logic [1:0] regsel;
	} bus_addr_s;

	// One word address, seen flat or split into its fields.
	typedef union packed {
		logic [`PERIPH_ADDR_W-1:0] word;
		bus_addr_s field;
	} bus_addr_u;

	// Which of the two hosts holds the bus.
	typedef logic [0:0] host_idx_t;

endpackage

`default_nettype wire

// ==== logic/periph_defines.svh ====
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus widths.
`define PERIPH_DATA_W 32
`define PERIPH_ADDR_W 4

// Device select values in the upper address bits.
`define PERIPH_DEV_TIMER0 2'd0
`define PERIPH_DEV_TIMER1 2'd1
`define PERIPH_DEV_IRQ 2'd2

// Timer register words.
`define TIMER_REG_CTRL 2'd0
`define TIMER_REG_PRESET 2'd1
`define TIMER_REG_COUNT 2'd2

// Interrupt controller register words.
`define IRQ_REG_PENDING 2'd0
`define IRQ_REG_MASK 2'd1
`define IRQ_REG_RAW 2'd2
`define IRQ_SOURCES 2

`endif
